//--- hdl/ras_pkg.sv
package ras_pkg;

  localparam int addr_w = 32;

  // Kind of a taken branch as seen by the shadow stack
  typedef enum logic [1:0] {
    op_none = 2'd0,
    op_call = 2'd1,
    op_ret  = 2'd2
  } ras_op_e;

  // Raw taken-branch event from the core
  typedef struct packed {
    logic              valid;
    logic              jal;
    logic [4:0]        rd;
    logic [31:0]       ins;
    logic [addr_w-1:0] next_addr;
    logic [addr_w-1:0] branoff;
  } branch_evt_t;

  typedef struct packed {
    ras_op_e           op;
    logic [addr_w-1:0] link_addr;
    logic [addr_w-1:0] target_addr;
  } ras_req_t;

  typedef struct packed {
    logic              full;
    logic              empty;
    logic              overflow;
    logic              mismatch;
    logic [4:0]        depth;
    logic [addr_w-1:0] last_bad_addr;
  } ras_status_t;

  // One-cold anode select with a0 pulling bit 0 low
  typedef enum logic [7:0] {
    a0 = 8'b1111_1110,
    a1 = 8'b1111_1101,
    a2 = 8'b1111_1011,
    a3 = 8'b1111_0111,
    a4 = 8'b1110_1111,
    a5 = 8'b1101_1111,
    a6 = 8'b1011_1111,
    a7 = 8'b0111_1111
  } anode_e;

  typedef logic [3:0] digit_t;

endpackage : ras_pkg

//--- hdl/tick_gen.sv
module tick_gen #(
  parameter int DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  output logic tick
);

  localparam int cw = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [cw-1:0] last = cw'(DIV - 1);

  logic [cw-1:0] cnt;

  // Pulse is registered so the first one lands DIV cycles after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      if (cnt == last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      tick <= (cnt == last);
    end
  end

endmodule : tick_gen

//--- hdl/branch_classifier.sv
module branch_classifier
  import ras_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  branch_evt_t evt,
  output ras_req_t    req
);

  ras_op_e           op_d;
  ras_op_e           op_q;
  logic [addr_w-1:0] link_q;
  logic [addr_w-1:0] target_q;
  logic              is_ret;
  logic              is_call;

  // c.jr ra and jalr x0, 0(ra)
  assign is_ret  = evt.valid && ((evt.ins == 32'h8082) || (evt.ins == 32'h8067));
  // Calls write the return address into ra
  assign is_call = evt.valid && evt.jal && (evt.rd == 5'd1);

  always_comb begin
    if (is_ret) begin
      op_d = op_ret;
    end else if (is_call) begin
      op_d = op_call;
    end else begin
      op_d = op_none;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_q <= op_none;
    end else begin
      op_q <= op_d;
    end
  end

  always_ff @(posedge clk) begin
    link_q   <= evt.next_addr;
    target_q <= evt.branoff;
  end

  assign req = '{op: op_q, link_addr: link_q, target_addr: target_q};

  a_op_from_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req.op != op_none) |-> $past(evt.valid)
  );

endmodule : branch_classifier

//--- hdl/shadow_stack.sv
module shadow_stack
  import ras_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst_n,
  input  ras_req_t    req,
  output ras_status_t status
);

  localparam int iw = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [4:0] depth_max = 5'(DEPTH);

  logic [addr_w-1:0] mem [DEPTH];
  logic [4:0]        depth_q;
  logic              overflow_q;
  logic              mismatch_q;
  logic [addr_w-1:0] bad_addr_q;

  logic              full;
  logic              empty;
  logic              push;
  logic              pop;
  logic              bad_ret;
  logic [iw-1:0]     wr_idx;
  logic [iw-1:0]     top_idx;
  logic [addr_w-1:0] top;

  assign full    = (depth_q == depth_max);
  assign empty   = (depth_q == 5'd0);
  assign wr_idx  = iw'(depth_q);
  assign top_idx = iw'(depth_q - 5'd1);
  assign top     = mem[top_idx];

  assign push = (req.op == op_call) && !full;
  assign pop  = (req.op == op_ret) && !empty;

  // Empty return counts as a mismatch as well
  assign bad_ret = (req.op == op_ret) && (empty || (top != req.target_addr));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_idx] <= req.link_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      depth_q    <= 5'd0;
      overflow_q <= 1'b0;
      mismatch_q <= 1'b0;
      bad_addr_q <= '0;
    end else begin
      if (push) begin
        depth_q <= depth_q + 5'd1;
      end else if (pop) begin
        depth_q <= depth_q - 5'd1;
      end

      // Dropped push sets a flag held until reset
      if ((req.op == op_call) && full) begin
        overflow_q <= 1'b1;
      end

      if (bad_ret) begin
        mismatch_q <= 1'b1;
        bad_addr_q <= req.target_addr;
      end
    end
  end

  assign status = '{
    full:          full,
    empty:         empty,
    overflow:      overflow_q,
    mismatch:      mismatch_q,
    depth:         depth_q,
    last_bad_addr: bad_addr_q
  };

  a_depth_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    depth_q <= depth_max
  );

  a_full_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(status.full && status.empty)
  );

endmodule : shadow_stack

//--- hdl/seg_scanner.sv
module seg_scanner
  import ras_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tick,
  input  logic [31:0] value,
  output anode_e      an,
  output logic [6:0]  seg
);

  anode_e an_q;
  anode_e an_nxt;
  digit_t nib_q;
  digit_t nib_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      an_q  <= a0;
      nib_q <= value[3:0];
    end else if (tick) begin
      an_q  <= an_nxt;
      nib_q <= nib_nxt;
    end
  end

  // Next anode in the scan
  always_comb begin
    case (an_q)
      a0:      an_nxt = a1;
      a1:      an_nxt = a2;
      a2:      an_nxt = a3;
      a3:      an_nxt = a4;
      a4:      an_nxt = a5;
      a5:      an_nxt = a6;
      a6:      an_nxt = a7;
      default: an_nxt = a0;
    endcase
  end

  // Nibble the next anode will show
  always_comb begin
    case (an_nxt)
      a1:      nib_nxt = value[7:4];
      a2:      nib_nxt = value[11:8];
      a3:      nib_nxt = value[15:12];
      a4:      nib_nxt = value[19:16];
      a5:      nib_nxt = value[23:20];
      a6:      nib_nxt = value[27:24];
      a7:      nib_nxt = value[31:28];
      default: nib_nxt = value[3:0];
    endcase
  end

  // Active-low segments with g in bit 0
  always_comb begin
    case (nib_q)
      4'h0:    seg = 7'b0000001;
      4'h1:    seg = 7'b1001111;
      4'h2:    seg = 7'b0010010;
      4'h3:    seg = 7'b0000110;
      4'h4:    seg = 7'b1001100;
      4'h5:    seg = 7'b0100100;
      4'h6:    seg = 7'b0100000;
      4'h7:    seg = 7'b0001111;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0000100;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b1100000;
      4'hc:    seg = 7'b0110001;
      4'hd:    seg = 7'b1000010;
      4'he:    seg = 7'b0110000;
      4'hf:    seg = 7'b0111000;
      default: seg = 7'b1111111;
    endcase
  end

  assign an = an_q;

  a_an_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    an_q inside {a0, a1, a2, a3, a4, a5, a6, a7}
  );

endmodule : seg_scanner

//--- hdl/ras_debug_top.sv
module ras_debug_top
  import ras_pkg::*;
#(
  parameter int DEPTH = 16,
  parameter int DIV   = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  branch_evt_t evt,
  output ras_status_t status,
  output anode_e      an,
  output logic [6:0]  seg
);

  logic     tick;
  ras_req_t req;

  tick_gen #(
    .DIV(DIV)
  ) u_tick (
    .clk  (clk),
    .rst_n(rst_n),
    .tick (tick)
  );

  branch_classifier u_classify (
    .clk  (clk),
    .rst_n(rst_n),
    .evt  (evt),
    .req  (req)
  );

  shadow_stack #(
    .DEPTH(DEPTH)
  ) u_stack (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .status(status)
  );

  // Display shows the target of the last bad return
  seg_scanner u_scan (
    .clk  (clk),
    .rst_n(rst_n),
    .tick (tick),
    .value(status.last_bad_addr),
    .an   (an),
    .seg  (seg)
  );

endmodule : ras_debug_top

//--- sim/ras_debug_tb.sv
module ras_debug_tb
  import ras_pkg::*;
();

  localparam int depth = 16;
  localparam int div   = 4;

  logic        clk;
  logic        rst_n;
  branch_evt_t evt;
  ras_status_t status;
  anode_e      an;
  logic [6:0]  seg;

  logic [31:0] rng;
  string       test_name;

  // Reference stack with the top entry at the back
  logic [31:0] model_stk[$];
  logic        model_ovf;
  logic        model_mis;
  logic [31:0] model_bad;
  ras_status_t exp_q[$];

  ras_debug_top #(.DEPTH(depth), .DIV(div)) uut (
    .clk   (clk),
    .rst_n (rst_n),
    .evt   (evt),
    .status(status),
    .an    (an),
    .seg   (seg)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Active-low segments abcdefg with g in bit 0
  function automatic logic [6:0] hex_to_seg(input logic [3:0] d);
    logic [6:0] s;
    s = 7'b1111111;
    case (d)
      4'h0: s = 7'b0000001;
      4'h1: s = 7'b1001111;
      4'h2: s = 7'b0010010;
      4'h3: s = 7'b0000110;
      4'h4: s = 7'b1001100;
      4'h5: s = 7'b0100100;
      4'h6: s = 7'b0100000;
      4'h7: s = 7'b0001111;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0000100;
      4'ha: s = 7'b0001000;
      4'hb: s = 7'b1100000;
      4'hc: s = 7'b0110001;
      4'hd: s = 7'b1000010;
      4'he: s = 7'b0110000;
      4'hf: s = 7'b0111000;
    endcase
    return s;
  endfunction

  function automatic ras_status_t model_status();
    ras_status_t s;
    s.full          = (model_stk.size() == depth);
    s.empty         = (model_stk.size() == 0);
    s.overflow      = model_ovf;
    s.mismatch      = model_mis;
    s.depth         = 5'(model_stk.size());
    s.last_bad_addr = model_bad;
    return s;
  endfunction

  task automatic model_apply(input branch_evt_t e);
    logic [31:0] top;
    if (e.valid && ((e.ins == 32'h8082) || (e.ins == 32'h8067))) begin
      // Empty return never matches
      top = ~e.branoff;
      if (model_stk.size() > 0) begin
        top = model_stk.pop_back();
      end
      if (top != e.branoff) begin
        model_mis = 1'b1;
        model_bad = e.branoff;
      end
    end else if (e.valid && e.jal && (e.rd == 5'd1)) begin
      if (model_stk.size() < depth) begin
        model_stk.push_back(e.next_addr);
      end else begin
        model_ovf = 1'b1;
      end
    end
  endtask

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_status(input string name, input ras_status_t exp, input ras_status_t act);
    if (act !== exp) begin
      fail_stop($sformatf("ERROR %s: status expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_display(input string name, input anode_e exp_an, input anode_e act_an,
                               input logic [6:0] exp_seg, input logic [6:0] act_seg);
    if (act_an !== exp_an) begin
      fail_stop($sformatf("ERROR %s: an expected %b actual %b", name, exp_an, act_an));
    end
    if (act_seg !== exp_seg) begin
      fail_stop($sformatf("ERROR %s: seg expected %b actual %b", name, exp_seg, act_seg));
    end
  endtask

  // Status lags the driven event by two edges
  task automatic step(input branch_evt_t e);
    evt = e;
    model_apply(e);
    exp_q.push_back(model_status());
    @(posedge clk);
    #1;
    check_status(test_name, exp_q.pop_front(), status);
  endtask

  task automatic flush();
    repeat (2) begin
      step('{valid: 1'b0, jal: 1'b0, rd: 5'd0, ins: 32'h0, next_addr: 32'h0, branoff: 32'h0});
    end
  endtask

  task automatic do_call();
    logic [31:0] ins;
    logic [31:0] link;
    ins  = next_rand();
    link = next_rand() & ~32'h3;
    step('{valid: 1'b1, jal: 1'b1, rd: 5'd1, ins: {ins[31:7], 7'h6f},
           next_addr: link, branoff: next_rand()});
  endtask

  task automatic do_ret(input logic [31:0] target, input logic enc);
    step('{valid: 1'b1, jal: 1'b0, rd: 5'd0, ins: enc ? 32'h8067 : 32'h8082,
           next_addr: next_rand(), branoff: target});
  endtask

  task automatic drain_stack();
    logic [31:0] r;
    while (model_stk.size() > 0) begin
      r = next_rand();
      do_ret(model_stk[$], r[0]);
    end
  endtask

  // Valid low, jal into a register other than ra, or a plain branch
  task automatic do_other();
    logic [31:0] r;
    r = next_rand();
    case (r[1:0])
      2'd0: step('{valid: 1'b0, jal: 1'b1, rd: 5'd1, ins: 32'h8082,
                   next_addr: next_rand(), branoff: next_rand()});
      2'd1: step('{valid: 1'b1, jal: 1'b1, rd: (r[6:2] == 5'd1) ? 5'd5 : r[6:2],
                   ins: {r[31:7], 7'h6f}, next_addr: next_rand(), branoff: next_rand()});
      default: step('{valid: 1'b1, jal: 1'b0, rd: r[6:2], ins: {r[31:7], 7'h63},
                      next_addr: next_rand(), branoff: next_rand()});
    endcase
  endtask

  task automatic scan_check(input int changes);
    anode_e     prev;
    anode_e     exp_an;
    logic [7:0] bits;
    int         waited;
    int         idx;
    prev = an;
    for (int k = 0; k < changes; k++) begin
      waited = 0;
      while (an == prev) begin
        if (waited == 4 * div) begin
          fail_stop("Timeout: the display anode did not advance");
        end
        @(posedge clk);
        #1;
        waited++;
      end
      // Next anode is the previous code rotated left by one
      bits   = prev;
      exp_an = anode_e'({bits[6:0], bits[7]});
      bits   = exp_an;
      idx    = 0;
      for (int i = 0; i < 8; i++) begin
        if (!bits[i]) begin
          idx = i;
        end
      end
      check_display(test_name, exp_an, an, hex_to_seg(model_bad[4 * idx +: 4]), seg);
      prev = an;
    end
  endtask

  initial begin
    int          n;
    logic [31:0] r;
    rng       = 32'h3606;
    rst_n     = 1'b0;
    evt       = '0;
    model_ovf = 1'b0;
    model_mis = 1'b0;
    model_bad = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "reset";
    exp_q.push_back(model_status());
    check_status(test_name, model_status(), status);
    check_display(test_name, a0, an, hex_to_seg(4'h0), seg);

    test_name = "matched";
    for (int round = 0; round < 6; round++) begin
      n = 2 + int'(next_rand() % 5);
      repeat (n) begin
        do_call();
      end
      for (int j = 0; j < n; j++) begin
        do_ret(model_stk[$], j[0]);
      end
    end
    flush();

    test_name = "bad_return";
    repeat (3) do_call();
    r = next_rand() | 32'h1;
    do_ret(model_stk[$] ^ r, 1'b0);
    repeat (3) do_call();
    drain_stack();
    flush();

    test_name = "overflow";
    n = depth + 1 + int'(next_rand() % 4);
    repeat (n) do_call();
    flush();
    drain_stack();
    test_name = "empty_return";
    do_ret(next_rand(), 1'b1);
    flush();

    test_name = "no_branch";
    repeat (3) do_call();
    repeat (24) do_other();
    flush();

    test_name = "random_mix";
    repeat (300) begin
      r = next_rand();
      case (r[2:0])
        3'd0, 3'd1: do_call();
        3'd2, 3'd3: do_ret((model_stk.size() > 0) ? model_stk[$] : next_rand(), r[8]);
        3'd4: do_ret(next_rand(), r[9]);
        3'd5: repeat (1 + r[5:4]) do_call();
        default: do_other();
      endcase
    end
    flush();

    test_name = "display_scan";
    scan_check(10);

    $display(">>> PASS");
    $finish;
  end

endmodule : ras_debug_tb

//--- build.f
hdl/ras_pkg.sv
hdl/tick_gen.sv
hdl/branch_classifier.sv
hdl/shadow_stack.sv
hdl/seg_scanner.sv
hdl/ras_debug_top.sv
sim/ras_debug_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module ras_debug_tb \
  -Mdir obj_dir -o ras_debug_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ras_debug_sim > sim.log 2>&1
rc=$?
cat sim.log
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
